// ==== src.f ====
+incdir+verilog
verilog/rob_pkg.sv
verilog/rob_wb_if.sv
verilog/fifo_ram.sv
verilog/rob.sv
verilog/arf.sv
verilog/operand_read.sv
verilog/rob_top.sv
tests/rob_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module rob_tb -o rob_sim

out=$(./obj_dir/rob_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

// ==== tests/rob_tb.sv ====
module rob_tb;
    import rob_pkg::*;

    localparam int MAX_ROWS    = 64;
    localparam int OP_DISPATCH = 0;
    localparam int OP_ALU_WB   = 1;
    localparam int OP_LSU_WB   = 2;
    localparam int OP_DUAL_WB  = 3;
    localparam int OP_IDLE     = 4;

    // One table row: stimulus for a cycle and what the outputs must show
    typedef struct packed {
        int      op;
        logic    dst_valid;
        arf_id_t dst_arf_id;
        pc_t     pc;
        logic    alu_valid;
        rob_id_t alu_id;
        reg_t    alu_data;
        logic    alu_misp;
        logic    lsu_valid;
        rob_id_t lsu_id;
        reg_t    lsu_data;
        logic    lsu_misp;
        logic    read_en;
        logic    src_renamed;
        arf_id_t src_arf_id;
        rob_id_t src_rob_id;
        logic    exp_src_ready;
        reg_t    exp_src_data;
        logic    alloc_en;
        logic    exp_ready;
        rob_id_t exp_id;
        logic    exp_retire;
        rob_id_t exp_ret_id;
        arf_id_t exp_ret_arf;
        reg_t    exp_ret_data;
        logic    exp_ret_dstv;
        logic    exp_flush;
        pc_t     exp_flush_pc;
    } row_t;

    logic    clk = 1'b0;
    logic    rst_n;
    logic    dispatch_valid;
    logic    dispatch_ready;
    rob_id_t dispatch_rob_id;
    logic    dispatch_dst_valid;
    arf_id_t dispatch_dst_arf_id;
    pc_t     dispatch_pc;
    logic    alu_wb_valid;
    rob_id_t alu_wb_rob_id;
    reg_t    alu_wb_reg_data;
    logic    alu_wb_br_mispredict;
    logic    lsu_wb_valid;
    rob_id_t lsu_wb_rob_id;
    reg_t    lsu_wb_reg_data;
    logic    lsu_wb_ld_mispredict;
    logic    retire;
    rob_id_t retire_rob_id;
    arf_id_t retire_arf_id;
    reg_t    retire_reg_data;
    logic    retire_dst_valid;
    logic    flush;
    pc_t     flush_pc;
    logic    src1_renamed;
    arf_id_t src1_arf_id;
    rob_id_t src1_rob_id;
    logic    src1_ready;
    reg_t    src1_data;
    logic    src2_renamed;
    arf_id_t src2_arf_id;
    rob_id_t src2_rob_id;
    logic    src2_ready;
    reg_t    src2_data;

    row_t    rows [MAX_ROWS];
    reg_t    wb_val [10];
    reg_t    arf_model [32];
    int      n_rows = 0;
    int      cur = 0;
    int      row_errors = 0;
    int      pass_count = 0;
    int      fail_count = 0;
    logic    table_built = 1'b0;

    rob_top rob_top_inst (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic string op_name(input int op);
        case (op)
            OP_DISPATCH: return "dispatch";
            OP_ALU_WB:   return "alu writeback";
            OP_LSU_WB:   return "lsu writeback";
            OP_DUAL_WB:  return "dual writeback";
            default:     return "read and idle";
        endcase
    endfunction

    task automatic start_row(input int op);
        rows[n_rows] = '0;
        rows[n_rows].op = op;
        cur = n_rows;
        n_rows++;
    endtask

    task automatic add_dispatch(input logic dst_valid, input arf_id_t arf_id, input pc_t pc,
                                input logic exp_ready, input rob_id_t exp_id);
        start_row(OP_DISPATCH);
        rows[cur].dst_valid  = dst_valid;
        rows[cur].dst_arf_id = arf_id;
        rows[cur].pc         = pc;
        rows[cur].alloc_en   = 1'b1;
        rows[cur].exp_ready  = exp_ready;
        rows[cur].exp_id     = exp_id;
    endtask

    task automatic add_writeback(input logic alu_on, input rob_id_t alu_id, input reg_t alu_data,
                                 input logic alu_misp, input logic lsu_on, input rob_id_t lsu_id,
                                 input reg_t lsu_data, input logic lsu_misp);
        start_row(alu_on && lsu_on ? OP_DUAL_WB : (alu_on ? OP_ALU_WB : OP_LSU_WB));
        rows[cur].alu_valid = alu_on;
        rows[cur].alu_id    = alu_id;
        rows[cur].alu_data  = alu_data;
        rows[cur].alu_misp  = alu_misp;
        rows[cur].lsu_valid = lsu_on;
        rows[cur].lsu_id    = lsu_id;
        rows[cur].lsu_data  = lsu_data;
        rows[cur].lsu_misp  = lsu_misp;
    endtask

    task automatic add_idle();
        start_row(OP_IDLE);
    endtask

    task automatic expect_alloc(input logic exp_ready, input rob_id_t exp_id);
        rows[cur].alloc_en  = 1'b1;
        rows[cur].exp_ready = exp_ready;
        rows[cur].exp_id    = exp_id;
    endtask

    task automatic expect_retire(input rob_id_t id, input arf_id_t arf_id, input reg_t data,
                                 input logic dst_valid);
        rows[cur].exp_retire   = 1'b1;
        rows[cur].exp_ret_id   = id;
        rows[cur].exp_ret_arf  = arf_id;
        rows[cur].exp_ret_data = data;
        rows[cur].exp_ret_dstv = dst_valid;
    endtask

    task automatic expect_flush(input pc_t pc);
        rows[cur].exp_flush    = 1'b1;
        rows[cur].exp_flush_pc = pc;
    endtask

    // Unrenamed reads take their expected value from the ARF model instead
    task automatic read_source(input logic renamed, input arf_id_t arf_id, input rob_id_t rob_id,
                               input logic exp_ready, input reg_t exp_data);
        rows[cur].read_en       = 1'b1;
        rows[cur].src_renamed   = renamed;
        rows[cur].src_arf_id    = arf_id;
        rows[cur].src_rob_id    = rob_id;
        rows[cur].exp_src_ready = exp_ready;
        rows[cur].exp_src_data  = exp_data;
    endtask

    task automatic build_table();
        logic [31:0] state;
        state = 32'd94;
        for (int i = 0; i < 10; i++) begin
            state = lcg_next(state);
            wb_val[i] = state;
        end
        // Fill all eight entries, IDs run 0 to 7
        for (int i = 0; i < 8; i++) begin
            add_dispatch(1'b1, arf_id_t'(i + 1), pc_t'(32'h200 + 4 * i), 1'b1, rob_id_t'(i));
        end
        add_writeback(1'b1, 3'd0, wb_val[0], 1'b0, 1'b0, 3'd0, '0, 1'b0);
        expect_alloc(1'b0, 3'd0);
        add_idle();
        expect_retire(3'd0, 5'd1, wb_val[0], 1'b1);
        expect_alloc(1'b0, 3'd0);
        add_dispatch(1'b1, 5'd20, 32'h220, 1'b1, 3'd0);
        // Branch mispredict at the head, a younger entry already done
        add_writeback(1'b1, 3'd1, wb_val[1], 1'b1, 1'b1, 3'd2, wb_val[2], 1'b0);
        add_dispatch(1'b1, 5'd9, 32'h300, 1'b0, 3'd0);
        expect_flush(32'h204);
        add_dispatch(1'b1, 5'd9, 32'h300, 1'b1, 3'd0);
        read_source(1'b0, 5'd2, 3'd0, 1'b1, '0);
        // Writebacks in reverse order, retire stays in order
        add_dispatch(1'b1, 5'd10, 32'h304, 1'b1, 3'd1);
        read_source(1'b1, 5'd0, 3'd0, 1'b0, '0);
        add_dispatch(1'b0, 5'd1, 32'h308, 1'b1, 3'd2);
        read_source(1'b0, 5'd3, 3'd0, 1'b1, '0);
        add_writeback(1'b1, 3'd2, wb_val[3], 1'b0, 1'b0, 3'd0, '0, 1'b0);
        read_source(1'b1, 5'd0, 3'd0, 1'b0, '0);
        add_writeback(1'b1, 3'd1, wb_val[4], 1'b0, 1'b0, 3'd0, '0, 1'b0);
        read_source(1'b1, 5'd0, 3'd2, 1'b1, wb_val[3]);
        add_writeback(1'b0, 3'd0, '0, 1'b0, 1'b1, 3'd0, wb_val[5], 1'b0);
        read_source(1'b1, 5'd0, 3'd0, 1'b0, '0);
        add_idle();
        expect_retire(3'd0, 5'd9, wb_val[5], 1'b1);
        read_source(1'b1, 5'd0, 3'd0, 1'b1, wb_val[5]);
        add_idle();
        expect_retire(3'd1, 5'd10, wb_val[4], 1'b1);
        read_source(1'b0, 5'd9, 3'd0, 1'b1, '0);
        add_idle();
        expect_retire(3'd2, 5'd1, wb_val[3], 1'b0);
        read_source(1'b0, 5'd10, 3'd0, 1'b1, '0);
        add_idle();
        read_source(1'b0, 5'd1, 3'd0, 1'b1, '0);
        // Both writeback ports in one cycle, the younger entry targets register 0
        add_dispatch(1'b1, 5'd12, 32'h400, 1'b1, 3'd3);
        add_dispatch(1'b1, 5'd0, 32'h404, 1'b1, 3'd4);
        add_writeback(1'b1, 3'd4, wb_val[6], 1'b0, 1'b1, 3'd3, wb_val[7], 1'b0);
        add_idle();
        expect_retire(3'd3, 5'd12, wb_val[7], 1'b1);
        add_idle();
        expect_retire(3'd4, 5'd0, wb_val[6], 1'b1);
        read_source(1'b0, 5'd12, 3'd0, 1'b1, '0);
        // Load mispredict from the LSU port
        add_dispatch(1'b1, 5'd14, 32'h408, 1'b1, 3'd5);
        add_dispatch(1'b1, 5'd15, 32'h40c, 1'b1, 3'd6);
        add_writeback(1'b1, 3'd6, wb_val[9], 1'b0, 1'b1, 3'd5, wb_val[8], 1'b1);
        add_idle();
        expect_flush(32'h408);
        expect_alloc(1'b0, 3'd0);
        add_dispatch(1'b1, 5'd16, 32'h500, 1'b1, 3'd0);
        read_source(1'b0, 5'd14, 3'd0, 1'b1, '0);
        add_idle();
        read_source(1'b0, 5'd15, 3'd0, 1'b1, '0);
    endtask

    task automatic drive_row(input row_t rw);
        dispatch_valid       = (rw.op == OP_DISPATCH);
        dispatch_dst_valid   = rw.dst_valid;
        dispatch_dst_arf_id  = rw.dst_arf_id;
        dispatch_pc          = rw.pc;
        alu_wb_valid         = rw.alu_valid;
        alu_wb_rob_id        = rw.alu_id;
        alu_wb_reg_data      = rw.alu_data;
        alu_wb_br_mispredict = rw.alu_misp;
        lsu_wb_valid         = rw.lsu_valid;
        lsu_wb_rob_id        = rw.lsu_id;
        lsu_wb_reg_data      = rw.lsu_data;
        lsu_wb_ld_mispredict = rw.lsu_misp;
        src1_renamed         = rw.src_renamed;
        src1_arf_id          = rw.src_arf_id;
        src1_rob_id          = rw.src_rob_id;
    endtask

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        row_errors++;
    endtask

    task automatic check_retire(input logic exp_retire, input rob_id_t exp_id,
                                input arf_id_t exp_arf, input reg_t exp_data, input logic exp_dstv);
        if (retire !== exp_retire) begin
            report_mismatch($sformatf("retire is %0b, expected %0b", retire, exp_retire));
        end else if (exp_retire && (retire_rob_id !== exp_id || retire_arf_id !== exp_arf ||
                     retire_reg_data !== exp_data || retire_dst_valid !== exp_dstv)) begin
            report_mismatch($sformatf("retire id %0d arf %0d data %h dst %0b, expected %0d %0d %h %0b",
                retire_rob_id, retire_arf_id, retire_reg_data, retire_dst_valid,
                exp_id, exp_arf, exp_data, exp_dstv));
        end
    endtask

    task automatic check_operand(input string name, input logic got_ready, input reg_t got_data,
                                 input logic exp_ready, input reg_t exp_data);
        if (got_ready !== exp_ready) begin
            report_mismatch($sformatf("%s ready is %0b, expected %0b", name, got_ready, exp_ready));
        end else if (exp_ready && got_data !== exp_data) begin
            report_mismatch($sformatf("%s data is %h, expected %h", name, got_data, exp_data));
        end
    endtask

    task automatic check_flush(input logic exp_flush, input pc_t exp_pc);
        if (flush !== exp_flush) begin
            report_mismatch($sformatf("flush is %0b, expected %0b", flush, exp_flush));
        end else if (exp_flush && flush_pc !== exp_pc) begin
            report_mismatch($sformatf("flush pc is %h, expected %h", flush_pc, exp_pc));
        end
    endtask

    task automatic check_alloc(input logic exp_ready, input rob_id_t exp_id);
        if (dispatch_ready !== exp_ready) begin
            report_mismatch($sformatf("dispatch ready is %0b, expected %0b",
                dispatch_ready, exp_ready));
        end else if (exp_ready && dispatch_rob_id !== exp_id) begin
            report_mismatch($sformatf("dispatch id is %0d, expected %0d", dispatch_rob_id, exp_id));
        end
    endtask

    // Limit grows with the table length
    initial begin
        wait (table_built);
        #(n_rows * 8 + 200);
        $display("Timeout: the table of %0d rows did not finish in time", n_rows);
        $display("sim failed");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        src2_renamed = 1'b0;
        src2_arf_id  = '0;
        src2_rob_id  = '0;
        drive_row('0);
        dispatch_valid = 1'b0;
        for (int i = 0; i < 32; i++) begin
            arf_model[i] = '0;
        end
        build_table();
        table_built = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            @(negedge clk);
            drive_row(rows[r]);
            #1;
            row_errors = 0;
            check_retire(rows[r].exp_retire, rows[r].exp_ret_id, rows[r].exp_ret_arf,
                         rows[r].exp_ret_data, rows[r].exp_ret_dstv);
            check_flush(rows[r].exp_flush, rows[r].exp_flush_pc);
            if (rows[r].alloc_en) begin
                check_alloc(rows[r].exp_ready, rows[r].exp_id);
            end
            if (rows[r].read_en && rows[r].src_renamed) begin
                check_operand("src1", src1_ready, src1_data,
                              rows[r].exp_src_ready, rows[r].exp_src_data);
            end else if (rows[r].read_en) begin
                check_operand("src1", src1_ready, src1_data, 1'b1,
                              arf_model[rows[r].src_arf_id]);
            end
            // Register 0 on the second source, every cycle
            check_operand("src2", src2_ready, src2_data, 1'b1, '0);
            // ARF write lands at the coming edge, register 0 keeps zero
            if (rows[r].exp_retire && rows[r].exp_ret_dstv && rows[r].exp_ret_arf != '0) begin
                arf_model[rows[r].exp_ret_arf] = rows[r].exp_ret_data;
            end
            if (row_errors == 0) begin
                pass_count++;
                $display("row %0d (%s): ok", r, op_name(rows[r].op));
            end else begin
                fail_count++;
                $display("row %0d (%s): %0d mismatches", r, op_name(rows[r].op), row_errors);
            end
        end
        @(negedge clk);
        drive_row('0);
        dispatch_valid = 1'b0;
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== verilog/rob_top.sv ====
module rob_top (
    input  logic             clk,
    input  logic             rst_n,

    // Dispatch
    input  logic             dispatch_valid,
    output logic             dispatch_ready,
    output rob_pkg::rob_id_t dispatch_rob_id,
    input  logic             dispatch_dst_valid,
    input  rob_pkg::arf_id_t dispatch_dst_arf_id,
    input  rob_pkg::pc_t     dispatch_pc,

    // ALU writeback
    input  logic             alu_wb_valid,
    input  rob_pkg::rob_id_t alu_wb_rob_id,
    input  rob_pkg::reg_t    alu_wb_reg_data,
    input  logic             alu_wb_br_mispredict,

    // LSU writeback
    input  logic             lsu_wb_valid,
    input  rob_pkg::rob_id_t lsu_wb_rob_id,
    input  rob_pkg::reg_t    lsu_wb_reg_data,
    input  logic             lsu_wb_ld_mispredict,

    // Retire
    output logic             retire,
    output rob_pkg::rob_id_t retire_rob_id,
    output rob_pkg::arf_id_t retire_arf_id,
    output rob_pkg::reg_t    retire_reg_data,
    output logic             retire_dst_valid,

    output logic             flush,
    output rob_pkg::pc_t     flush_pc,

    // Operand sources
    input  logic             src1_renamed,
    input  rob_pkg::arf_id_t src1_arf_id,
    input  rob_pkg::rob_id_t src1_rob_id,
    output logic             src1_ready,
    output rob_pkg::reg_t    src1_data,
    input  logic             src2_renamed,
    input  rob_pkg::arf_id_t src2_arf_id,
    input  rob_pkg::rob_id_t src2_rob_id,
    output logic             src2_ready,
    output rob_pkg::reg_t    src2_data
);
    import rob_pkg::*;

    rob_dispatch_data_t dispatch_data;
    logic               commit_en;
    rob_id_t            rob_id_src1;
    rob_id_t            rob_id_src2;
    logic               rob_reg_ready_src1;
    logic               rob_reg_ready_src2;
    reg_t               rob_reg_data_src1;
    reg_t               rob_reg_data_src2;
    arf_id_t            arf_id_src1;
    arf_id_t            arf_id_src2;
    reg_t               arf_data_src1;
    reg_t               arf_data_src2;

    rob_wb_if alu_wb ();
    rob_wb_if lsu_wb ();

    assign dispatch_data = '{
        dst_valid:  dispatch_dst_valid,
        dst_arf_id: dispatch_dst_arf_id,
        pc:         dispatch_pc
    };

    assign alu_wb.valid      = alu_wb_valid;
    assign alu_wb.rob_id     = alu_wb_rob_id;
    assign alu_wb.reg_data   = alu_wb_reg_data;
    assign alu_wb.mispredict = alu_wb_br_mispredict;

    assign lsu_wb.valid      = lsu_wb_valid;
    assign lsu_wb.rob_id     = lsu_wb_rob_id;
    assign lsu_wb.reg_data   = lsu_wb_reg_data;
    assign lsu_wb.mispredict = lsu_wb_ld_mispredict;

    // Commit enable is already qualified by the destination bit
    assign retire_dst_valid = commit_en;

    rob rob_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .dispatch_valid     (dispatch_valid),
        .dispatch_ready     (dispatch_ready),
        .dispatch_rob_id    (dispatch_rob_id),
        .dispatch_data      (dispatch_data),
        .alu_wb             (alu_wb),
        .lsu_wb             (lsu_wb),
        .retire             (retire),
        .retire_rob_id      (retire_rob_id),
        .commit_en          (commit_en),
        .commit_arf_id      (retire_arf_id),
        .commit_data        (retire_reg_data),
        .flush              (flush),
        .flush_pc           (flush_pc),
        .rob_id_src1        (rob_id_src1),
        .rob_reg_ready_src1 (rob_reg_ready_src1),
        .rob_reg_data_src1  (rob_reg_data_src1),
        .rob_id_src2        (rob_id_src2),
        .rob_reg_ready_src2 (rob_reg_ready_src2),
        .rob_reg_data_src2  (rob_reg_data_src2)
    );

    arf arf_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .commit_en     (commit_en),
        .commit_arf_id (retire_arf_id),
        .commit_data   (retire_reg_data),
        .rd_id_a       (arf_id_src1),
        .rd_data_a     (arf_data_src1),
        .rd_id_b       (arf_id_src2),
        .rd_data_b     (arf_data_src2)
    );

    operand_read src1_read (
        .src_renamed   (src1_renamed),
        .src_arf_id    (src1_arf_id),
        .src_rob_id    (src1_rob_id),
        .rob_id        (rob_id_src1),
        .rob_reg_ready (rob_reg_ready_src1),
        .rob_reg_data  (rob_reg_data_src1),
        .arf_id        (arf_id_src1),
        .arf_data      (arf_data_src1),
        .src_ready     (src1_ready),
        .src_data      (src1_data)
    );

    operand_read src2_read (
        .src_renamed   (src2_renamed),
        .src_arf_id    (src2_arf_id),
        .src_rob_id    (src2_rob_id),
        .rob_id        (rob_id_src2),
        .rob_reg_ready (rob_reg_ready_src2),
        .rob_reg_data  (rob_reg_data_src2),
        .arf_id        (arf_id_src2),
        .arf_data      (arf_data_src2),
        .src_ready     (src2_ready),
        .src_data      (src2_data)
    );

endmodule

// ==== verilog/operand_read.sv ====
module operand_read (
    // Source operand as seen by issue
    input  logic             src_renamed,
    input  rob_pkg::arf_id_t src_arf_id,
    input  rob_pkg::rob_id_t src_rob_id,

    // Lookup into the ROB
    output rob_pkg::rob_id_t rob_id,
    input  logic             rob_reg_ready,
    input  rob_pkg::reg_t    rob_reg_data,

    // Lookup into the ARF
    output rob_pkg::arf_id_t arf_id,
    input  rob_pkg::reg_t    arf_data,

    // Resolved operand
    output logic             src_ready,
    output rob_pkg::reg_t    src_data
);

    // Both lookups run every cycle, the rename bit picks one
    assign rob_id = src_rob_id;
    assign arf_id = src_arf_id;

    // Pending producer in the ROB, value may not be there yet
    // Architectural values are always ready
    assign src_ready = src_renamed ? rob_reg_ready : 1'b1;
    assign src_data  = src_renamed ? rob_reg_data : arf_data;

endmodule

// ==== verilog/arf.sv ====
`include "rob_cfg.svh"

module arf (
    input  logic             clk,
    input  logic             rst_n,

    // Retire write port
    input  logic             commit_en,
    input  rob_pkg::arf_id_t commit_arf_id,
    input  rob_pkg::reg_t    commit_data,

    // Operand read ports
    input  rob_pkg::arf_id_t rd_id_a,
    output rob_pkg::reg_t    rd_data_a,
    input  rob_pkg::arf_id_t rd_id_b,
    output rob_pkg::reg_t    rd_data_b
);
    import rob_pkg::*;

    localparam int N_REGS = 2 ** `ARF_ID_WIDTH;

    reg_t regs [N_REGS];

    // Register 0 is never written, so it stays at its reset value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_en && (commit_arf_id != '0)) begin
            regs[commit_arf_id] <= commit_data;
        end
    end

    // Plain array reads, no bypass from the commit port
    assign rd_data_a = regs[rd_id_a];
    assign rd_data_b = regs[rd_id_b];

endmodule

// ==== verilog/rob.sv ====
`include "rob_cfg.svh"

module rob (
    input  logic                        clk,
    input  logic                        rst_n,

    // Dispatch
    input  logic                        dispatch_valid,
    output logic                        dispatch_ready,
    output rob_pkg::rob_id_t            dispatch_rob_id,
    input  rob_pkg::rob_dispatch_data_t dispatch_data,

    // Writeback
    rob_wb_if.rob                       alu_wb,
    rob_wb_if.rob                       lsu_wb,

    // Retire and commit to ARF
    output logic                        retire,
    output rob_pkg::rob_id_t            retire_rob_id,
    output logic                        commit_en,
    output rob_pkg::arf_id_t            commit_arf_id,
    output rob_pkg::reg_t               commit_data,

    output logic                        flush,
    output rob_pkg::pc_t                flush_pc,

    // Operand lookups
    input  rob_pkg::rob_id_t            rob_id_src1,
    output logic                        rob_reg_ready_src1,
    output rob_pkg::reg_t               rob_reg_data_src1,
    input  rob_pkg::rob_id_t            rob_id_src2,
    output logic                        rob_reg_ready_src2,
    output rob_pkg::reg_t               rob_reg_data_src2
);
    import rob_pkg::*;

    rob_entry_t                         dispatch_entry;
    rob_entry_t                         head_entry;
    rob_entry_t                         src1_entry;
    rob_entry_t                         src2_entry;
    rob_entry_t                         alu_entry;
    rob_entry_t                         lsu_entry;
    rob_entry_t [`ROB_N_ENTRIES-1:0]    entries;
    logic                               enq_ready;
    logic                               head_valid;
    logic                               head_done;
    logic                               head_mispredict;
    logic                               alu_target_live;
    logic                               lsu_target_live;

    // New entries start with no result and no mispredict
    assign dispatch_entry = '{
        dst_valid:     dispatch_data.dst_valid,
        dst_arf_id:    dispatch_data.dst_arf_id,
        pc:            dispatch_data.pc,
        ld_mispredict: 1'b0,
        br_mispredict: 1'b0,
        reg_ready:     1'b0,
        reg_data:      '0
    };

    // Writeback merge, static fields are kept
    always_comb begin
        alu_entry               = entries[alu_wb.rob_id];
        alu_entry.reg_ready     = 1'b1;
        alu_entry.reg_data      = alu_wb.reg_data;
        alu_entry.br_mispredict = alu_wb.mispredict;
    end

    always_comb begin
        lsu_entry               = entries[lsu_wb.rob_id];
        lsu_entry.reg_ready     = 1'b1;
        lsu_entry.reg_data      = lsu_wb.reg_data;
        lsu_entry.ld_mispredict = lsu_wb.mispredict;
    end

    fifo_ram rob_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .enq_valid (dispatch_valid),
        .enq_ready (enq_ready),
        .enq_data  (dispatch_entry),
        .enq_addr  (dispatch_rob_id),
        .deq_valid (head_valid),
        .deq_ready (retire),
        .deq_data  (head_entry),
        .deq_addr  (retire_rob_id),
        .flush     (flush),
        .rd_addr_a (rob_id_src1),
        .rd_data_a (src1_entry),
        .rd_addr_b (rob_id_src2),
        .rd_data_b (src2_entry),
        .wr_en_a   (alu_wb.valid),
        .wr_addr_a (alu_wb.rob_id),
        .wr_data_a (alu_entry),
        .wr_en_b   (lsu_wb.valid),
        .wr_addr_b (lsu_wb.rob_id),
        .wr_data_b (lsu_entry),
        .entries   (entries)
    );

    assign rob_reg_ready_src1 = src1_entry.reg_ready;
    assign rob_reg_data_src1  = src1_entry.reg_data;
    assign rob_reg_ready_src2 = src2_entry.reg_ready;
    assign rob_reg_data_src2  = src2_entry.reg_data;

    // Head decides: retire if clean, flush if mispredicted
    assign head_done       = head_valid && head_entry.reg_ready;
    assign head_mispredict = head_entry.br_mispredict || head_entry.ld_mispredict;
    assign retire          = head_done && !head_mispredict;
    assign flush           = head_done && head_mispredict;
    assign flush_pc        = head_entry.pc;

    assign commit_en     = retire && head_entry.dst_valid;
    assign commit_arf_id = head_entry.dst_arf_id;
    assign commit_data   = head_entry.reg_data;

    // No new entries while the window is being discarded
    assign dispatch_ready = enq_ready && !flush;

    // Live window runs from head up to tail
    function automatic logic is_live(input rob_id_t id);
        logic live;
        if (!head_valid) begin
            live = 1'b0;
        end else if (!enq_ready) begin
            live = 1'b1;
        end else if (retire_rob_id < dispatch_rob_id) begin
            live = (id >= retire_rob_id) && (id < dispatch_rob_id);
        end else begin
            live = (id >= retire_rob_id) || (id < dispatch_rob_id);
        end
        return live;
    endfunction

    always_comb begin
        alu_target_live = is_live(alu_wb.rob_id);
        lsu_target_live = is_live(lsu_wb.rob_id);
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (alu_wb.valid |-> alu_target_live) and (lsu_wb.valid |-> lsu_target_live))
        else $error("rob: writeback to an empty entry");
    assert property (@(posedge clk) disable iff (!rst_n)
        !(alu_wb.valid && lsu_wb.valid && (alu_wb.rob_id == lsu_wb.rob_id)))
        else $error("rob: both writeback ports hit the same entry");

endmodule

// ==== verilog/fifo_ram.sv ====
`include "rob_cfg.svh"

module fifo_ram (
    input  logic                                          clk,
    input  logic                                          rst_n,

    // Enqueue at tail
    input  logic                                          enq_valid,
    output logic                                          enq_ready,
    input  rob_pkg::rob_entry_t                           enq_data,
    output rob_pkg::rob_id_t                              enq_addr,

    // Dequeue at head
    output logic                                          deq_valid,
    input  logic                                          deq_ready,
    output rob_pkg::rob_entry_t                           deq_data,
    output rob_pkg::rob_id_t                              deq_addr,

    input  logic                                          flush,

    // Random-access reads
    input  rob_pkg::rob_id_t                              rd_addr_a,
    output rob_pkg::rob_entry_t                           rd_data_a,
    input  rob_pkg::rob_id_t                              rd_addr_b,
    output rob_pkg::rob_entry_t                           rd_data_b,

    // Random-access writes
    input  logic                                          wr_en_a,
    input  rob_pkg::rob_id_t                              wr_addr_a,
    input  rob_pkg::rob_entry_t                           wr_data_a,
    input  logic                                          wr_en_b,
    input  rob_pkg::rob_id_t                              wr_addr_b,
    input  rob_pkg::rob_entry_t                           wr_data_b,

    // Every entry, for read-modify-write by the owner
    output rob_pkg::rob_entry_t [`ROB_N_ENTRIES-1:0]      entries
);
    import rob_pkg::*;

    rob_entry_t                 mem [`ROB_N_ENTRIES];
    logic [`ROB_N_ENTRIES-1:0]  occupied;
    // Extra MSB is the wrap bit
    logic [`ROB_ID_WIDTH:0]     head_ptr;
    logic [`ROB_ID_WIDTH:0]     tail_ptr;
    rob_id_t                    head_idx;
    rob_id_t                    tail_idx;
    logic                       full;
    logic                       empty;
    logic                       enq_fire;
    logic                       deq_fire;

    assign head_idx = head_ptr[`ROB_ID_WIDTH-1:0];
    assign tail_idx = tail_ptr[`ROB_ID_WIDTH-1:0];

    // Same slot, opposite lap means full
    assign full  = (head_idx == tail_idx) && (head_ptr[`ROB_ID_WIDTH] != tail_ptr[`ROB_ID_WIDTH]);
    assign empty = (head_ptr == tail_ptr);

    assign enq_ready = !full;
    assign enq_addr  = tail_idx;
    assign deq_valid = occupied[head_idx];
    assign deq_data  = mem[head_idx];
    assign deq_addr  = head_idx;

    // Flush wins over both ends
    assign enq_fire = enq_valid && enq_ready && !flush;
    assign deq_fire = deq_valid && deq_ready && !flush;

    assign rd_data_a = mem[rd_addr_a];
    assign rd_data_b = mem[rd_addr_b];

    always_comb begin
        for (int i = 0; i < `ROB_N_ENTRIES; i++) begin
            entries[i] = mem[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            occupied <= '0;
        end else begin
            if (enq_fire) begin
                tail_ptr           <= tail_ptr + 1'b1;
                occupied[tail_idx] <= 1'b1;
            end
            if (deq_fire) begin
                head_ptr           <= head_ptr + 1'b1;
                occupied[head_idx] <= 1'b0;
            end
        end
    end

    // Entry storage, writes only land in live slots
    always_ff @(posedge clk) begin
        if (enq_fire) begin
            mem[tail_idx] <= enq_data;
        end
        if (wr_en_a && occupied[wr_addr_a]) begin
            mem[wr_addr_a] <= wr_data_a;
        end
        if (wr_en_b && occupied[wr_addr_b]) begin
            mem[wr_addr_b] <= wr_data_b;
        end
    end

    // Pointer state and occupied bits must agree
    assert property (@(posedge clk) disable iff (!rst_n) enq_fire |-> !occupied[tail_idx])
        else $error("fifo_ram: enqueue while full");
    assert property (@(posedge clk) disable iff (!rst_n) deq_fire |-> !empty)
        else $error("fifo_ram: dequeue while empty");

endmodule

// ==== verilog/rob_wb_if.sv ====
// Result bus from one execution unit into the ROB
interface rob_wb_if;
    import rob_pkg::*;

    logic    valid;
    rob_id_t rob_id;
    reg_t    reg_data;
    // Branch mispredict on the ALU port, load mispredict on the LSU port
    logic    mispredict;

    modport unit (
        output valid,
        output rob_id,
        output reg_data,
        output mispredict
    );

    modport rob (
        input valid,
        input rob_id,
        input reg_data,
        input mispredict
    );

endinterface

// ==== verilog/rob_pkg.sv ====
`include "rob_cfg.svh"

package rob_pkg;

    // Scalar fields
    typedef logic [`ROB_ID_WIDTH-1:0] rob_id_t;
    typedef logic [`ARF_ID_WIDTH-1:0] arf_id_t;
    typedef logic [`REG_WIDTH-1:0]    reg_t;
    typedef logic [`PC_WIDTH-1:0]     pc_t;

    // What dispatch hands over for a new instruction
    typedef struct packed {
        logic    dst_valid;
        arf_id_t dst_arf_id;
        pc_t     pc;
    } rob_dispatch_data_t;

    // One stored ROB entry
    // Result fields are filled in by writeback
    typedef struct packed {
        logic    dst_valid;
        arf_id_t dst_arf_id;
        pc_t     pc;
        logic    ld_mispredict;
        logic    br_mispredict;
        logic    reg_ready;
        reg_t    reg_data;
    } rob_entry_t;

endpackage

// ==== verilog/rob_cfg.svh ====
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// ROB sizing
`define ROB_N_ENTRIES 8
`define ROB_ID_WIDTH  3

// Architectural state widths
`define ARF_ID_WIDTH  5
`define REG_WIDTH     32
`define PC_WIDTH      32

`endif
